// ==== rtl/icmu_params.svh ====
// icmu sizing parameters
`ifndef ICMU_PARAMS_SVH
`define ICMU_PARAMS_SVH

// request lines, priority rises with index
`define ICMU_NUM_IRQ 8

// request id and level width
`define ICMU_LVL_W 3

// saved program counter width
`define ICMU_PC_W 24

// context frames, shallow so eight levels can fill it
`define ICMU_STACK_DEPTH 4

// pointer counts 0 to depth inclusive
`define ICMU_PTR_W 3

`endif

// ==== rtl/icmu_irq_pkg.sv ====
// interrupt request types
`default_nettype none

`include "icmu_params.svh"

package icmu_irq_pkg;

    // request id, also used as a priority level
    typedef logic [`ICMU_LVL_W-1:0] irq_id_t;

    // arbiter result
    typedef struct packed {
        logic    valid;
        irq_id_t id;
    } irq_grant_t;

    // level now in service
    typedef struct packed {
        logic    active;
        irq_id_t level;
    } irq_level_t;

endpackage

`default_nettype wire

// ==== rtl/icmu_ctx_pkg.sv ====
// saved context types
`default_nettype none

`include "icmu_params.svh"

package icmu_ctx_pkg;

    import icmu_irq_pkg::*;

    typedef logic [`ICMU_PC_W-1:0] pc_t;

    // one stack word, 32 bits
    typedef struct packed {
        pc_t        pc;
        irq_level_t prev;
        logic [3:0] pad;
    } ctx_frame_t;

endpackage

`default_nettype wire

// ==== rtl/icmu_pend_arbiter.sv ====
// pending request arbiter
`timescale 1ns/1ps
`default_nettype none

`include "icmu_params.svh"

module icmu_pend_arbiter (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire [`ICMU_NUM_IRQ-1:0]        irq_req,
    input  wire icmu_irq_pkg::irq_level_t  cur_level,
    input  wire                            ack,
    input  wire [`ICMU_LVL_W-1:0]          ack_id,
    output icmu_irq_pkg::irq_grant_t       grant
);

    import icmu_irq_pkg::*;

    logic [`ICMU_NUM_IRQ-1:0] req_q;
    logic [`ICMU_NUM_IRQ-1:0] req_rise;
    logic [`ICMU_NUM_IRQ-1:0] ack_mask;
    logic [`ICMU_NUM_IRQ-1:0] pending;

    // ~~~~~~~~~~~~~~~~~~~~
    // edge capture

    assign req_rise = irq_req & ~req_q;

    always_comb begin
        ack_mask = '0;
        if (ack) begin
            ack_mask[ack_id] = 1'b1;
        end
    end

    // a fresh edge wins over a same-cycle ack of that bit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q   <= '0;
            pending <= '0;
        end else begin
            req_q   <= irq_req;
            pending <= (pending & ~ack_mask) | req_rise;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // fixed priority select

    // scan upward so the highest eligible index is kept
    always_comb begin
        grant = '0;
        for (int i = 0; i < `ICMU_NUM_IRQ; i++) begin
            if (pending[i] && (!cur_level.active || irq_id_t'(i) > cur_level.level)) begin
                grant.valid = 1'b1;
                grant.id    = irq_id_t'(i);
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/icmu_context_stack.sv ====
// context frame stack
`timescale 1ns/1ps
`default_nettype none

`include "icmu_params.svh"

module icmu_context_stack (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            save,
    input  wire                            restore,
    input  wire icmu_ctx_pkg::ctx_frame_t  save_frame,
    output icmu_ctx_pkg::ctx_frame_t       pop_frame,
    output logic                           stack_empty,
    output logic                           stack_full
);

    import icmu_ctx_pkg::*;

    localparam int ADDR_W = `ICMU_PTR_W - 1;

    typedef logic [`ICMU_PTR_W-1:0] ptr_t;

    localparam ptr_t LAST_PTR = ptr_t'(`ICMU_STACK_DEPTH - 1);

    ctx_frame_t        mem [`ICMU_STACK_DEPTH];
    ptr_t              ptr;
    ptr_t              ptr_dec;
    logic [ADDR_W-1:0] wr_addr;
    logic [ADDR_W-1:0] rd_addr;

    assign ptr_dec     = ptr - ptr_t'(1);
    assign wr_addr     = ptr[ADDR_W-1:0];
    assign rd_addr     = ptr_dec[ADDR_W-1:0];
    assign stack_empty = (ptr == '0);

    // ~~~~~~~~~~~~~~~~~~~~
    // pointer and full flag

    // full is looked ahead one save early so it comes out registered
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr        <= '0;
            stack_full <= 1'b0;
        end else if (save) begin
            ptr        <= ptr + ptr_t'(1);
            stack_full <= (ptr == LAST_PTR);
        end else if (restore) begin
            ptr        <= ptr_dec;
            stack_full <= 1'b0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // storage

    always_ff @(posedge clk) begin
        if (save) begin
            mem[wr_addr] <= save_frame;
        end
        // top entry lands in pop_frame one edge after restore
        if (restore) begin
            pop_frame <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/icmu_nest_ctrl.sv ====
// interrupt nesting controller
`timescale 1ns/1ps
`default_nettype none

`include "icmu_params.svh"

module icmu_nest_ctrl (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire icmu_irq_pkg::irq_grant_t  grant,
    input  wire                            iret,
    input  wire [`ICMU_PC_W-1:0]           pc_in,
    input  wire icmu_ctx_pkg::ctx_frame_t  pop_frame,
    input  wire                            stack_empty,
    input  wire                            stack_full,
    output logic                           save,
    output logic                           restore,
    output icmu_ctx_pkg::ctx_frame_t       save_frame,
    output logic                           ack,
    output logic [`ICMU_LVL_W-1:0]         ack_id,
    output icmu_irq_pkg::irq_level_t       cur_level,
    output logic                           take,
    output logic [`ICMU_LVL_W-1:0]         take_id,
    output logic                           resume_valid,
    output logic [`ICMU_PC_W-1:0]          resume_pc
);

    import icmu_irq_pkg::*;

    logic       restore_q;
    logic       grant_ok;
    irq_level_t level_next;

    // ~~~~~~~~~~~~~~~~~~~~
    // take and return decode

    // iret on an empty stack is dropped here
    assign restore = iret && !stack_empty;

    // no take in the iret cycle or the one after it
    assign grant_ok = grant.valid && !stack_full && !restore && !restore_q;

    assign save   = grant_ok;
    assign ack    = grant_ok;
    assign ack_id = grant.id;

    assign save_frame = '{pc: pc_in, prev: cur_level, pad: '0};

    always_comb begin
        level_next = cur_level;
        if (grant_ok) begin
            level_next.active = 1'b1;
            level_next.level  = grant.id;
        end else if (restore_q) begin
            // pop_frame is valid here, one edge after restore
            level_next = pop_frame.prev;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // state and strobes

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            restore_q    <= 1'b0;
            take         <= 1'b0;
            resume_valid <= 1'b0;
            cur_level    <= '0;
        end else begin
            restore_q    <= restore;
            take         <= grant_ok;
            resume_valid <= restore_q;
            cur_level    <= level_next;
        end
    end

    // payload follows its strobe
    always_ff @(posedge clk) begin
        if (grant_ok) begin
            take_id <= grant.id;
        end
        if (restore_q) begin
            resume_pc <= pop_frame.pc;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/icmu_top.sv ====
// interrupt context unit top
`timescale 1ns/1ps
`default_nettype none

`include "icmu_params.svh"

module icmu_top (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire [`ICMU_NUM_IRQ-1:0]        irq_req,
    input  wire [`ICMU_PC_W-1:0]           pc_in,
    input  wire                            iret,
    output wire                            take,
    output wire [`ICMU_LVL_W-1:0]          take_id,
    output wire                            resume_valid,
    output wire [`ICMU_PC_W-1:0]           resume_pc,
    output wire icmu_irq_pkg::irq_level_t  cur_level,
    output wire                            stack_full
);

    import icmu_irq_pkg::*;
    import icmu_ctx_pkg::*;

    wire irq_grant_t             grant;
    wire                         ack;
    wire [`ICMU_LVL_W-1:0]       ack_id;
    wire                         save;
    wire                         restore;
    wire ctx_frame_t             save_frame;
    wire ctx_frame_t             pop_frame;
    wire                         stack_empty;

    icmu_pend_arbiter u_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .irq_req   (irq_req),
        .cur_level (cur_level),
        .ack       (ack),
        .ack_id    (ack_id),
        .grant     (grant)
    );

    icmu_context_stack u_stack (
        .clk         (clk),
        .rst_n       (rst_n),
        .save        (save),
        .restore     (restore),
        .save_frame  (save_frame),
        .pop_frame   (pop_frame),
        .stack_empty (stack_empty),
        .stack_full  (stack_full)
    );

    icmu_nest_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .grant        (grant),
        .iret         (iret),
        .pc_in        (pc_in),
        .pop_frame    (pop_frame),
        .stack_empty  (stack_empty),
        .stack_full   (stack_full),
        .save         (save),
        .restore      (restore),
        .save_frame   (save_frame),
        .ack          (ack),
        .ack_id       (ack_id),
        .cur_level    (cur_level),
        .take         (take),
        .take_id      (take_id),
        .resume_valid (resume_valid),
        .resume_pc    (resume_pc)
    );

endmodule

`default_nettype wire

// ==== tests/icmu_props.sv ====
// icmu concurrent checks
`timescale 1ns/1ps
`default_nettype none

`include "icmu_params.svh"

module icmu_props (
    input wire                            clk,
    input wire                            rst_n,
    input wire                            take,
    input wire [`ICMU_LVL_W-1:0]          take_id,
    input wire                            resume_valid,
    input wire icmu_irq_pkg::irq_level_t  cur_level,
    input wire                            stack_full
);

    int fail_count = 0;

    // ~~~~~~~~~~~~~~~~~~~~
    // take rules

    a_take_outranks: assert property (@(posedge clk) disable iff (!rst_n)
        take |-> (!$past(cur_level.active) || take_id > $past(cur_level.level)))
    else begin
        fail_count++;
        $error("take did not outrank the previous level");
    end

    a_take_sets_level: assert property (@(posedge clk) disable iff (!rst_n)
        take |-> (cur_level.active && cur_level.level == take_id))
    else begin
        fail_count++;
        $error("cur_level does not follow take_id");
    end

    // full stack is the only back-pressure
    a_no_take_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        take |-> !$past(stack_full))
    else begin
        fail_count++;
        $error("take issued while the stack was full");
    end

    a_take_resume_apart: assert property (@(posedge clk) disable iff (!rst_n)
        !(take && resume_valid))
    else begin
        fail_count++;
        $error("take and resume_valid in the same cycle");
    end

    a_full_means_active: assert property (@(posedge clk) disable iff (!rst_n)
        stack_full |-> cur_level.active)
    else begin
        fail_count++;
        $error("stack_full while idle");
    end

endmodule

bind icmu_top icmu_props u_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .take         (take),
    .take_id      (take_id),
    .resume_valid (resume_valid),
    .cur_level    (cur_level),
    .stack_full   (stack_full)
);

`default_nettype wire

// ==== tests/icmu_tb.sv ====
// icmu testbench
`timescale 1ns/1ps
`default_nettype none

`include "icmu_params.svh"

module icmu_tb;

    import icmu_irq_pkg::*;
    import icmu_ctx_pkg::*;

    localparam int PERIOD       = 40;
    localparam int NUM_PHASES   = 5;
    localparam int PHASE_CYCLES = 800;

    logic                     clk = 1'b0;
    logic                     rst_n;
    logic [`ICMU_NUM_IRQ-1:0] irq_req;
    logic [`ICMU_PC_W-1:0]    pc_in;
    logic                     iret;
    wire                      take;
    wire  [`ICMU_LVL_W-1:0]   take_id;
    wire                      resume_valid;
    wire  [`ICMU_PC_W-1:0]    resume_pc;
    wire irq_level_t          cur_level;
    wire                      stack_full;

    ctx_frame_t            model_q[$];
    logic [`ICMU_PC_W-1:0] pc_prev;
    irq_level_t            lvl_prev;
    logic                  iret_s1;
    logic                  iret_s2;
    int                    take_count = 0;
    int                    takes_expected = 0;
    logic [`ICMU_LVL_W-1:0] last_take_id;
    integer                seed = 32'h901a_ac72;

    icmu_top i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .irq_req      (irq_req),
        .pc_in        (pc_in),
        .iret         (iret),
        .take         (take),
        .take_id      (take_id),
        .resume_valid (resume_valid),
        .resume_pc    (resume_pc),
        .cur_level    (cur_level),
        .stack_full   (stack_full)
    );

    always #(PERIOD / 2) clk = ~clk;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // reference model

    // pc walks so each saved frame is distinct
    always @(posedge clk) begin
        pc_in    <= pc_in + 24'h00_0135;
        pc_prev  <= pc_in;
        lvl_prev <= cur_level;
        iret_s1  <= iret && (model_q.size() != 0);
        iret_s2  <= iret_s1;
    end

    always @(negedge clk) begin
        ctx_frame_t top;
        ctx_frame_t frame;
        if (rst_n) begin
            assert (resume_valid == iret_s2) else stop_on_error($sformatf(
                "MISMATCH resume_valid got %h exp %h", resume_valid, iret_s2));
            if (take) begin
                assert (!lvl_prev.active || take_id > lvl_prev.level) else stop_on_error(
                    $sformatf("take id %0d does not outrank level %0d",
                              take_id, lvl_prev.level));
                assert (cur_level == {1'b1, take_id}) else stop_on_error($sformatf(
                    "MISMATCH cur_level got %h exp %h", cur_level, {1'b1, take_id}));
                frame = '{pc: pc_prev, prev: lvl_prev, pad: '0};
                model_q.push_back(frame);
                take_count++;
                last_take_id = take_id;
            end
            if (resume_valid && model_q.size() != 0) begin
                top = model_q.pop_back();
                assert (resume_pc == top.pc) else stop_on_error($sformatf(
                    "MISMATCH resume_pc got %h exp %h", resume_pc, top.pc));
                assert (cur_level == top.prev) else stop_on_error($sformatf(
                    "MISMATCH cur_level got %h exp %h", cur_level, top.prev));
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // drivers

    task automatic pulse_req(input int id);
        irq_req[id] <= 1'b1;
        @(posedge clk);
        irq_req[id] <= 1'b0;
    endtask

    task automatic do_iret;
        iret <= 1'b1;
        @(posedge clk);
        iret <= 1'b0;
        repeat (3) @(posedge clk);
    endtask

    task automatic expect_take(input int id);
        int n;
        n = 0;
        takes_expected++;
        while (take_count < takes_expected && n < 50) begin
            @(posedge clk);
            n++;
        end
        if (take_count < takes_expected) begin
            stop_on_error($sformatf("no take for request %0d within 50 cycles", id));
        end
        assert (last_take_id == id) else stop_on_error($sformatf(
            "MISMATCH take_id got %h exp %h", last_take_id, id));
        @(posedge clk);
    endtask

    initial begin
        #(PERIOD * (NUM_PHASES * PHASE_CYCLES + 100));
        stop_on_error("watchdog timeout, simulation did not finish");
    end

    initial begin
        int r;
        rst_n   = 1'b0;
        irq_req = '0;
        pc_in   = 24'h10_0000;
        iret    = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // quiet after reset
        repeat (3) begin
            @(negedge clk);
            assert (!take && !resume_valid && !stack_full && !cur_level.active)
            else stop_on_error($sformatf(
                "MISMATCH take/resume_valid/stack_full/cur_level.active got %h/%h/%h/%h exp 0/0/0/0",
                take, resume_valid, stack_full, cur_level.active));
        end
        @(posedge clk);

        // single request, take exactly two edges later
        irq_req[3] <= 1'b1;
        @(posedge clk);
        irq_req[3] <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        assert (take && take_id == 3) else stop_on_error($sformatf(
            "MISMATCH take/take_id got %h/%h exp 1/3", take, take_id));
        takes_expected++;
        @(posedge clk);
        do_iret();

        // lower request waits behind the nest
        pulse_req(2);
        expect_take(2);
        pulse_req(1);
        pulse_req(5);
        expect_take(5);
        do_iret();
        do_iret();
        expect_take(1);
        do_iret();

        // fill the stack
        for (int i = 1; i <= 4; i++) begin
            pulse_req(i);
            expect_take(i);
        end
        @(negedge clk);
        assert (stack_full) else stop_on_error($sformatf(
            "MISMATCH stack_full got %h exp 1", stack_full));
        @(posedge clk);
        pulse_req(6);
        repeat (6) @(posedge clk);
        assert (take_count == takes_expected) else stop_on_error("take while stack full");
        do_iret();
        expect_take(6);
        while (model_q.size() != 0) begin
            do_iret();
        end
        do_iret();

        // random requests and returns
        for (int i = 0; i < 150; i++) begin
            r = $random(seed);
            case (r[1:0])
                2'd0, 2'd1: pulse_req(r[4:2]);
                2'd2: do_iret();
                default: @(posedge clk);
            endcase
        end
        repeat (30) do_iret();
        repeat (5) @(posedge clk);

        if (i_dut.u_props.fail_count != 0 || model_q.size() != 0) begin
            stop_on_error("concurrent assertion failed or frames left unreturned");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== icmu_top.f ====
+incdir+rtl
rtl/icmu_irq_pkg.sv
rtl/icmu_ctx_pkg.sv
rtl/icmu_pend_arbiter.sv
rtl/icmu_context_stack.sv
rtl/icmu_nest_ctrl.sv
rtl/icmu_top.sv
tests/icmu_props.sv
tests/icmu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the icmu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module icmu_tb -f icmu_top.f -o icmu_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/icmu_sim)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx '\*\* PASS \*\*'; then
    exit 0
fi

echo "pass message not found"
exit 1
